// ==== test/dds_scope_cases.txt ====
// one case per line, hex: wave mod phase_inc fsk_inc raw_step keyed_step
// wave 0 square 1 saw 2 triangle 3 silent, mod 0 none 1 ask 2 fsk 3 bpsk
// steps are per capture, phase_inc / 65536 with 16 cycles per capture
1 0 00030000 00000000 003 003
// square and silent shapes
0 0 00050000 00000000 005 005
3 0 00040000 00000000 004 004
2 0 00020000 00000000 002 002
// wrap across the top of the sawtooth
1 0 00FF0000 00000000 0FF 0FF
// amplitude keying
2 1 00020000 00000000 002 002
1 1 00070000 00000000 007 007
0 1 00010000 00000000 001 001
// phase keying
1 3 00040000 00000000 004 004
2 3 00060000 00000000 006 006
0 3 00030000 00000000 003 003
// fsk stays last, channels drift apart after it
1 2 00030000 00020000 003 005

// ==== dds_scope_top.f ====
design/dds_scope_pkg.sv
design/axil_ctrl_regs.sv
design/lfsr_ticker.sv
design/dds_core.sv
design/signal_generator.sv
design/scope_sampler.sv
design/dds_scope_top.sv
test/tb_clock_gen.sv
test/tb_dds_scope.sv

// ==== Makefile ====
TOP = tb_dds_scope

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f dds_scope_top.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -x "Testbench passed" > /dev/null

lint:
	verilator --lint-only --timing -f dds_scope_top.f --top-module $(TOP)
	verilator --lint-only design/dds_scope_pkg.sv design/axil_ctrl_regs.sv \
		design/lfsr_ticker.sv design/dds_core.sv design/signal_generator.sv \
		design/scope_sampler.sv design/dds_scope_top.sv --top-module dds_scope_top

clean:
	rm -rf obj_dir

// ==== test/tb_dds_scope.sv ====
module tb_dds_scope;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 1000;   // cycles per wait loop
   localparam int MAX_CASES  = 16;
   localparam int SAMPLE_DIV = 16;

   logic                         CLK_25MHZ;
   logic                         reset_from_key;
   dds_scope_pkg::axil_req_t     axil_req;
   dds_scope_pkg::axil_rsp_t     axil_rsp;
   dds_scope_pkg::scope_sample_t sample;
   logic                         sample_valid;
   logic                         sample_ready;

   logic [31:0] cases_mem [0:6*MAX_CASES-1];   // six words per case
   int          error_count;
   int          check_count;

   tb_clock_gen i_clock_gen
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key)
   );

   dds_scope_top #(.TICK_DIV(256), .SAMPLE_DIV(SAMPLE_DIV)) i_dut
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .axil_req       (axil_req),
      .axil_rsp       (axil_rsp),
      .sample         (sample),
      .sample_valid   (sample_valid),
      .sample_ready   (sample_ready)
   );

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("FAIL %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("Testbench failed");
      $finish;
   endtask

   // next state by the shift rule, bit 4 xor bit 2 into bit 0
   function automatic logic [4:0] lfsr_step(input logic [4:0] x);
      return {x[3:0], x[4] ^ x[2]};
   endfunction

   function automatic logic signed [11:0] negate_saturated(input logic signed [11:0] v);
      if (v == 12'sh800)
         return 12'sh7ff;
      return -v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // AXI4-Lite master
   ////////////////////////////////////////////////////////////////////////////

   task automatic axil_write(input logic [5:0] addr, input logic [31:0] data);
      int t;
      @(posedge CLK_25MHZ);
      axil_req.awvalid <= 1'b1;
      axil_req.awaddr  <= addr;
      axil_req.wvalid  <= 1'b1;
      axil_req.wdata   <= data;
      axil_req.bready  <= 1'b1;
      t = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         t++;
      end while (!(axil_rsp.awready && axil_rsp.wready) && t < WAIT_LIMIT);
      if (t >= WAIT_LIMIT)
         abort_on_timeout("awready and wready");
      @(posedge CLK_25MHZ);
      axil_req.awvalid <= 1'b0;
      axil_req.wvalid  <= 1'b0;
      t = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         t++;
      end while (!axil_rsp.bvalid && t < WAIT_LIMIT);
      if (t >= WAIT_LIMIT)
         abort_on_timeout("bvalid");
      check_equal(32'(axil_rsp.bresp), 32'(dds_scope_pkg::RESP_OKAY), "bresp");
      @(posedge CLK_25MHZ);
      axil_req.bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [5:0] addr, output logic [31:0] data);
      int t;
      @(posedge CLK_25MHZ);
      axil_req.arvalid <= 1'b1;
      axil_req.araddr  <= addr;
      axil_req.rready  <= 1'b1;
      t = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         t++;
      end while (!axil_rsp.arready && t < WAIT_LIMIT);
      if (t >= WAIT_LIMIT)
         abort_on_timeout("arready");
      @(posedge CLK_25MHZ);
      axil_req.arvalid <= 1'b0;
      t = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         t++;
      end while (!axil_rsp.rvalid && t < WAIT_LIMIT);
      if (t >= WAIT_LIMIT)
         abort_on_timeout("rvalid");
      data = axil_rsp.rdata;
      check_equal(32'(axil_rsp.rresp), 32'(dds_scope_pkg::RESP_OKAY), "rresp");
      @(posedge CLK_25MHZ);
      axil_req.rready <= 1'b0;
   endtask

   task automatic write_and_verify(input logic [5:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      axil_write(addr, data);
      axil_read(addr, rd);
      check_equal(rd, data, $sformatf("readback of offset %0h", addr));
   endtask

   // short random stall, well under one capture period so nothing is dropped
   task automatic receive_sample(output dds_scope_pkg::scope_sample_t s);
      int t;
      int stall;
      stall = $urandom % 8;
      @(posedge CLK_25MHZ);
      sample_ready <= 1'b0;
      repeat (stall) @(posedge CLK_25MHZ);
      sample_ready <= 1'b1;
      t = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         t++;
      end while (!sample_valid && t < WAIT_LIMIT);
      if (t >= WAIT_LIMIT)
         abort_on_timeout("sample_valid");
      s = sample;
      @(posedge CLK_25MHZ);   // transfer edge
      sample_ready <= 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // one case from the file
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_case(input int c);
      logic [1:0]                   wave;
      logic [1:0]                   modsel;
      logic [11:0]                  raw_step;
      logic [11:0]                  key_step;
      logic [11:0]                  d_raw;
      logic [11:0]                  d_mod;
      logic                         have_prev;
      logic                         key;
      int                           n;
      dds_scope_pkg::scope_sample_t s;
      dds_scope_pkg::scope_sample_t prev;
      wave     = cases_mem[6*c][1:0];
      modsel   = cases_mem[6*c+1][1:0];
      raw_step = cases_mem[6*c+4][11:0];
      key_step = cases_mem[6*c+5][11:0];
      axil_write(dds_scope_pkg::REG_WAVE, cases_mem[6*c]);
      axil_write(dds_scope_pkg::REG_MOD, cases_mem[6*c+1]);
      axil_write(dds_scope_pkg::REG_PHASE_INC, cases_mem[6*c+2]);
      axil_write(dds_scope_pkg::REG_FSK_INC, cases_mem[6*c+3]);
      repeat (3) receive_sample(s);   // stale and settling samples
      have_prev = 1'b0;
      prev      = '0;
      n         = 32 + ($urandom % 16);
      for (int i = 0; i < n; i++)
      begin
         receive_sample(s);
         key = s.lfsr[0];
         check_equal(32'(s.lfsr != 5'd0), 32'd1, "lfsr is zero");
         if (have_prev && s.lfsr != prev.lfsr)
            check_equal(32'(s.lfsr), 32'(lfsr_step(prev.lfsr)), "lfsr step");
         d_raw = s.raw - prev.raw;
         d_mod = s.modulated - prev.modulated;
         case (wave)
            2'd0: check_equal(32'(s.raw == 12'sh7ff || s.raw == 12'sh800), 32'd1, "square");
            2'd1: if (have_prev) check_equal(32'(d_raw), 32'(raw_step), "sawtooth step");
            2'd2: check_equal(32'(s.raw[0]), 32'd0, "triangle odd");
            default: check_equal(32'(s.raw), 32'd0, "silent");
         endcase
         case (modsel)
            2'd0: check_equal(32'(s.modulated), 32'(s.raw), "unmodulated");
            2'd1: check_equal(32'(s.modulated), key ? 32'(s.raw) : 32'd0, "ask");
            2'd3:
            begin
               check_equal(32'(s.modulated), key ? 32'(s.raw) : 32'(negate_saturated(s.raw)),
                           "bpsk");
            end
            default:
            begin
               if (have_prev && s.lfsr == prev.lfsr)
                  check_equal(32'(d_mod), key ? 32'(key_step) : 32'(raw_step), "fsk step");
            end
         endcase
         prev      = s;
         have_prev = 1'b1;
      end
   endtask

   initial
   begin
      logic [31:0]                  rd;
      logic [31:0]                  ov_before;
      dds_scope_pkg::scope_sample_t held;
      int                           t;
      int                           n_stall;
      axil_req     = '0;
      sample_ready = 1'b1;
      error_count  = 0;
      check_count  = 0;
      void'($urandom(32'h417a));
      for (int i = 0; i < 6*MAX_CASES; i++)
         cases_mem[i] = 32'hffff_ffff;   // end marker
      $readmemh("test/dds_scope_cases.txt", cases_mem);

      t = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         t++;
      end while (reset_from_key && t < WAIT_LIMIT);
      if (t >= WAIT_LIMIT)
         abort_on_timeout("reset release");

      // register map
      write_and_verify(dds_scope_pkg::REG_WAVE, 32'd2);
      write_and_verify(dds_scope_pkg::REG_MOD, 32'd1);
      write_and_verify(dds_scope_pkg::REG_PHASE_INC, 32'h1234_0000);
      write_and_verify(dds_scope_pkg::REG_FSK_INC, 32'hABCD_0000);
      axil_write(dds_scope_pkg::REG_OVERRUN, 32'h0000_FFFF);
      axil_read(dds_scope_pkg::REG_OVERRUN, rd);
      check_equal(rd, 32'd0, "overrun write ignored");
      axil_write(dds_scope_pkg::REG_LFSR, 32'h0000_001F);
      axil_read(dds_scope_pkg::REG_LFSR, rd);
      check_equal(rd, 32'h0000_0001, "lfsr write ignored");   // first tick still ahead
      axil_write(6'h18, 32'hDEAD_BEEF);
      axil_read(dds_scope_pkg::REG_WAVE, rd);
      check_equal(rd, 32'd2, "wave after status writes");
      axil_read(dds_scope_pkg::REG_MOD, rd);
      check_equal(rd, 32'd1, "mod after status writes");
      axil_read(dds_scope_pkg::REG_PHASE_INC, rd);
      check_equal(rd, 32'h1234_0000, "phase_inc after status writes");
      axil_read(dds_scope_pkg::REG_FSK_INC, rd);
      check_equal(rd, 32'hABCD_0000, "fsk_inc after status writes");
      axil_read(6'h18, rd);
      check_equal(rd, 32'd0, "unmapped read");
      axil_read(6'h3C, rd);
      check_equal(rd, 32'd0, "unmapped read");

      for (int c = 0; c < MAX_CASES; c++)
      begin
         if (cases_mem[6*c] === 32'hffff_ffff)
            break;
         run_case(c);
      end

      // back-pressure
      axil_read(dds_scope_pkg::REG_OVERRUN, ov_before);
      n_stall = 3 + ($urandom % 4);
      t = 0;
      do
      begin
         @(negedge CLK_25MHZ);
         t++;
      end while (!sample_valid && t < WAIT_LIMIT);
      if (t >= WAIT_LIMIT)
         abort_on_timeout("sample_valid before stall");
      held = sample;
      repeat (n_stall * SAMPLE_DIV)
      begin
         @(negedge CLK_25MHZ);
         check_equal(32'(sample_valid), 32'd1, "valid during stall");
         check_equal(32'(sample), 32'(held), "sample during stall");
      end
      axil_read(dds_scope_pkg::REG_OVERRUN, rd);
      check_equal(32'(rd >= ov_before + n_stall - 1), 32'd1, "overrun count rise");
      @(posedge CLK_25MHZ);
      sample_ready <= 1'b1;

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen
(
   output logic CLK_25MHZ,
   output logic reset_from_key
);

   timeunit 1ns;
   timeprecision 1ps;

   // 25 MHz board clock
   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;
   end

   initial
   begin
      reset_from_key = 1'b1;
      repeat (10) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
   end

endmodule

// ==== design/dds_scope_top.sv ====
module dds_scope_top
#(
   parameter int unsigned TICK_DIV   = 2_500_000,
   parameter int unsigned SAMPLE_DIV = 70_000
)
(
   input  logic                         CLK_25MHZ,
   input  logic                         reset_from_key,
   input  dds_scope_pkg::axil_req_t     axil_req,
   output dds_scope_pkg::axil_rsp_t     axil_rsp,
   output dds_scope_pkg::scope_sample_t sample,
   output logic                         sample_valid,
   input  logic                         sample_ready
);

   dds_scope_pkg::dds_ctrl_t ctrl;
   dds_scope_pkg::lfsr_t     lfsr;
   dds_scope_pkg::sample_t   raw;
   dds_scope_pkg::sample_t   modulated;
   dds_scope_pkg::overrun_t  overrun;

   ////////////////////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////////////////////

   axil_ctrl_regs i_axil_ctrl_regs
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .axil_req       (axil_req),
      .axil_rsp       (axil_rsp),
      .ctrl           (ctrl),
      .lfsr           (lfsr),      // readback
      .overrun        (overrun)
   );

   ////////////////////////////////////////////////////////////////////////////
   // processing
   ////////////////////////////////////////////////////////////////////////////

   lfsr_ticker #(.TICK_DIV(TICK_DIV)) i_lfsr_ticker
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr           (lfsr)
   );

   signal_generator i_signal_generator
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .ctrl           (ctrl),
      .lfsr           (lfsr),
      .raw            (raw),
      .modulated      (modulated)
   );

   // output side
   scope_sampler #(.SAMPLE_DIV(SAMPLE_DIV)) i_scope_sampler
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .raw            (raw),
      .modulated      (modulated),
      .lfsr           (lfsr),
      .sample         (sample),
      .sample_valid   (sample_valid),
      .sample_ready   (sample_ready),
      .overrun        (overrun)
   );

endmodule

// ==== design/scope_sampler.sv ====
module scope_sampler
#(
   parameter int unsigned SAMPLE_DIV = 70_000
)
(
   input  logic                         CLK_25MHZ,
   input  logic                         reset_from_key,
   input  dds_scope_pkg::sample_t       raw,
   input  dds_scope_pkg::sample_t       modulated,
   input  dds_scope_pkg::lfsr_t         lfsr,
   output dds_scope_pkg::scope_sample_t sample,
   output logic                         sample_valid,
   input  logic                         sample_ready,
   output dds_scope_pkg::overrun_t      overrun
);

   localparam int CNT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

   logic [CNT_W-1:0] cap_cnt;
   logic             capture;
   logic             stalled;   // sample held and not leaving this cycle

   assign capture = (cap_cnt == '0);
   assign stalled = sample_valid && !sample_ready;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || capture)
         cap_cnt <= CNT_W'(SAMPLE_DIV - 1);
      else
         cap_cnt <= cap_cnt - 1'b1;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sample_valid <= 1'b0;
         overrun      <= '0;
      end
      else if (capture && stalled)
      begin
         if (overrun != '1)
            overrun <= overrun + 1'b1;   // new capture dropped
      end
      else if (capture)
      begin
         sample_valid <= 1'b1;
      end
      else if (sample_valid && sample_ready)
      begin
         sample_valid <= 1'b0;
      end
   end

   // payload, all three fields from the same cycle
   always_ff @(posedge CLK_25MHZ)
   begin
      if (capture && !stalled)
         sample <= '{raw: raw, modulated: modulated, lfsr: lfsr};
   end

   a_hold_stable : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      stalled |=> sample_valid && $stable(sample));

endmodule

// ==== design/signal_generator.sv ====
module signal_generator
(
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  dds_scope_pkg::dds_ctrl_t ctrl,
   input  dds_scope_pkg::lfsr_t     lfsr,
   output dds_scope_pkg::sample_t   raw,
   output dds_scope_pkg::sample_t   modulated
);

   dds_scope_pkg::phase_t  mod_inc;
   dds_scope_pkg::sample_t raw_wave;
   dds_scope_pkg::sample_t mod_wave;
   logic                   key;

   assign key = lfsr[0];

   // fsk shifts the second channel up while the key is one
   assign mod_inc = (ctrl.mod_sel == dds_scope_pkg::MOD_FSK && key) ?
                    ctrl.phase_inc + ctrl.fsk_inc : ctrl.phase_inc;

   dds_core i_raw_core
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (ctrl.phase_inc),
      .wave_sel       (ctrl.wave_sel),
      .wave           (raw_wave)
   );

   dds_core i_mod_core
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (mod_inc),
      .wave_sel       (ctrl.wave_sel),
      .wave           (mod_wave)
   );

   ////////////////////////////////////////////////////////////////////////////
   // keying stage, raw delayed alongside so both channels line up
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      raw <= raw_wave;
      case (ctrl.mod_sel)
         dds_scope_pkg::MOD_ASK:  modulated <= key ? mod_wave : '0;
         dds_scope_pkg::MOD_BPSK:
         begin
            if (key)
               modulated <= mod_wave;
            else if (mod_wave == dds_scope_pkg::SAMPLE_MIN)
               modulated <= dds_scope_pkg::SAMPLE_MAX;   // -(-2048) saturates
            else
               modulated <= -mod_wave;
         end
         default: modulated <= mod_wave;   // none and fsk pass through
      endcase
   end

endmodule

// ==== design/dds_core.sv ====
module dds_core
(
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  dds_scope_pkg::phase_t    phase_inc,
   input  dds_scope_pkg::wave_sel_t wave_sel,
   output dds_scope_pkg::sample_t   wave
);

   dds_scope_pkg::phase_t phase;
   logic [11:0]           p;        // top phase bits
   logic [10:0]           tri_idx;  // folded for the falling half

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + phase_inc;
   end

   assign p       = phase[31:20];
   assign tri_idx = p[11] ? ~p[10:0] : p[10:0];

   // one cycle behind the accumulator
   always_ff @(posedge CLK_25MHZ)
   begin
      case (wave_sel)
         dds_scope_pkg::WAVE_SQUARE:
         begin
            wave <= p[11] ? dds_scope_pkg::SAMPLE_MIN : dds_scope_pkg::SAMPLE_MAX;
         end
         dds_scope_pkg::WAVE_SAW:
         begin
            wave <= {~p[11], p[10:0]};   // offset binary to signed
         end
         dds_scope_pkg::WAVE_TRIANGLE:
         begin
            wave <= {~tri_idx[10], tri_idx[9:0], 1'b0};   // 2*idx - 2048
         end
         default:
         begin
            wave <= '0;   // silent
         end
      endcase
   end

endmodule

// ==== design/lfsr_ticker.sv ====
module lfsr_ticker
#(
   parameter int unsigned TICK_DIV = 2_500_000
)
(
   input  logic                 CLK_25MHZ,
   input  logic                 reset_from_key,
   output dds_scope_pkg::lfsr_t lfsr
);

   localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [CNT_W-1:0] tick_cnt;
   logic             tick;

   assign tick = (tick_cnt == '0);

   // step divider, one tick per TICK_DIV cycles
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         tick_cnt <= CNT_W'(TICK_DIV - 1);
      else if (tick)
         tick_cnt <= CNT_W'(TICK_DIV - 1);
      else
         tick_cnt <= tick_cnt - 1'b1;
   end

   // fibonacci form, taps 5 and 3, period 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr <= 5'b00001;
      end
      else if (tick)
      begin
         lfsr <= {lfsr[3:0], lfsr[4] ^ lfsr[2]};
      end
   end

   a_lfsr_nonzero : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr != '0);

endmodule

// ==== design/axil_ctrl_regs.sv ====
module axil_ctrl_regs
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  dds_scope_pkg::axil_req_t axil_req,
   output dds_scope_pkg::axil_rsp_t axil_rsp,
   output dds_scope_pkg::dds_ctrl_t ctrl,
   input  dds_scope_pkg::lfsr_t     lfsr,
   input  dds_scope_pkg::overrun_t  overrun
);

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_WRESP,
      ST_RRESP
   } state_t;

   state_t                    state;
   logic                      wr_accept;
   logic                      rd_accept;
   dds_scope_pkg::axil_data_t rdata_next;
   dds_scope_pkg::axil_data_t rdata_q;

   // write needs address and data in the same cycle, and beats a read
   assign wr_accept = (state == ST_IDLE) && axil_req.awvalid && axil_req.wvalid;
   assign rd_accept = (state == ST_IDLE) && axil_req.arvalid && !wr_accept;

   always_comb
   begin
      axil_rsp.awready = (state == ST_IDLE);
      axil_rsp.wready  = (state == ST_IDLE);
      axil_rsp.arready = (state == ST_IDLE) && !(axil_req.awvalid && axil_req.wvalid);
      axil_rsp.bvalid  = (state == ST_WRESP);
      axil_rsp.bresp   = dds_scope_pkg::RESP_OKAY;
      axil_rsp.rvalid  = (state == ST_RRESP);
      axil_rsp.rdata   = rdata_q;
      axil_rsp.rresp   = dds_scope_pkg::RESP_OKAY;
   end

   // read mux, unmapped offsets give zero
   always_comb
   begin
      case (axil_req.araddr)
         dds_scope_pkg::REG_WAVE:      rdata_next = {30'd0, ctrl.wave_sel};
         dds_scope_pkg::REG_MOD:       rdata_next = {30'd0, ctrl.mod_sel};
         dds_scope_pkg::REG_PHASE_INC: rdata_next = ctrl.phase_inc;
         dds_scope_pkg::REG_FSK_INC:   rdata_next = ctrl.fsk_inc;
         dds_scope_pkg::REG_LFSR:      rdata_next = {27'd0, lfsr};
         dds_scope_pkg::REG_OVERRUN:   rdata_next = {16'd0, overrun};
         default:                      rdata_next = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // transaction FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         state <= ST_IDLE;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (wr_accept)
                  state <= ST_WRESP;
               else if (rd_accept)
                  state <= ST_RRESP;
            end
            ST_WRESP: if (axil_req.bready) state <= ST_IDLE;
            ST_RRESP: if (axil_req.rready) state <= ST_IDLE;
            default:  state <= ST_IDLE;
         endcase
      end
   end

   // control fields change on the accepting edge
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         ctrl <= '0;
      end
      else if (wr_accept)
      begin
         case (axil_req.awaddr)
            dds_scope_pkg::REG_WAVE:      ctrl.wave_sel  <= axil_req.wdata[1:0];
            dds_scope_pkg::REG_MOD:       ctrl.mod_sel   <= axil_req.wdata[1:0];
            dds_scope_pkg::REG_PHASE_INC: ctrl.phase_inc <= axil_req.wdata;
            dds_scope_pkg::REG_FSK_INC:   ctrl.fsk_inc   <= axil_req.wdata;
            default:                      ;   // status and holes
         endcase
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (rd_accept)
         rdata_q <= rdata_next;
   end

   a_one_response : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !(axil_rsp.bvalid && axil_rsp.rvalid));

   a_bvalid_hold : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

endmodule

// ==== design/dds_scope_pkg.sv ====
package dds_scope_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths that carry a meaning
   ////////////////////////////////////////////////////////////////////////////

   typedef logic        [31:0] phase_t;      // accumulator and increment
   typedef logic signed [11:0] sample_t;     // two's complement waveform
   typedef logic        [4:0]  lfsr_t;
   typedef logic        [1:0]  wave_sel_t;
   typedef logic        [1:0]  mod_sel_t;
   typedef logic        [15:0] overrun_t;    // saturating
   typedef logic        [5:0]  axil_addr_t;
   typedef logic        [31:0] axil_data_t;
   typedef logic        [1:0]  axil_resp_t;

   // waveform codes
   localparam wave_sel_t WAVE_SQUARE   = 2'd0;
   localparam wave_sel_t WAVE_SAW      = 2'd1;
   localparam wave_sel_t WAVE_TRIANGLE = 2'd2;
   localparam wave_sel_t WAVE_SILENT   = 2'd3;

   // modulation codes, keyed by lfsr bit 0
   localparam mod_sel_t MOD_NONE = 2'd0;
   localparam mod_sel_t MOD_ASK  = 2'd1;
   localparam mod_sel_t MOD_FSK  = 2'd2;
   localparam mod_sel_t MOD_BPSK = 2'd3;

   localparam sample_t SAMPLE_MAX = 12'sh7ff;   // +2047
   localparam sample_t SAMPLE_MIN = 12'sh800;   // -2048

   ////////////////////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////////////////////

   localparam axil_addr_t REG_WAVE      = 6'h00;
   localparam axil_addr_t REG_MOD       = 6'h04;
   localparam axil_addr_t REG_PHASE_INC = 6'h08;
   localparam axil_addr_t REG_FSK_INC   = 6'h0C;
   localparam axil_addr_t REG_LFSR      = 6'h10;   // read only
   localparam axil_addr_t REG_OVERRUN   = 6'h14;   // read only

   localparam axil_resp_t RESP_OKAY = 2'b00;

   // control word, 68 bits
   typedef struct packed {
      wave_sel_t wave_sel;
      mod_sel_t  mod_sel;
      phase_t    phase_inc;
      phase_t    fsk_inc;
   } dds_ctrl_t;

   // one scope capture, 29 bits
   typedef struct packed {
      sample_t raw;
      sample_t modulated;
      lfsr_t   lfsr;
   } scope_sample_t;

   typedef struct packed {
      logic       awvalid;
      axil_addr_t awaddr;
      logic       wvalid;
      axil_data_t wdata;
      logic       bready;
      logic       arvalid;
      axil_addr_t araddr;
      logic       rready;
   } axil_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      axil_resp_t bresp;
      logic       arready;
      logic       rvalid;
      axil_data_t rdata;
      axil_resp_t rresp;
   } axil_rsp_t;

endpackage
